/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_miss_handler
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_TEXT ?= All tests passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

/* files.f */
verilog/cache_pkg.sv
verilog/mem_pkg.sv
verilog/mshr_ack_if.sv
verilog/mshr.sv
verilog/miss_issue.sv
verilog/refill_fifo.sv
verilog/refill_ctrl.sv
verilog/miss_handler.sv
tests/tb_clock.sv
tests/tb_miss_handler.sv

/* tests/tb_clock.sv */
`timescale 1ns/100ps

module tb_clock #(
    parameter real Period      = 8.0,
    parameter int  ResetCycles = 5
) (
    output logic clk_o,
    output logic rst_no
);

    initial begin
        clk_o = 1'b0;
        forever #(Period / 2) clk_o = ~clk_o;
    end

    initial begin
        rst_no = 1'b0;
        repeat (ResetCycles) @(posedge clk_o);
        @(negedge clk_o);
        rst_no = 1'b1;
    end

endmodule

/* tests/tb_miss_handler.sv */
`timescale 1ns/100ps

module tb_miss_handler;

    localparam int Ways = 4;
    localparam int Last = cache_pkg::CHUNKS_PER_LINE - 1;

    logic                   clk_i;
    logic                   rst_ni;
    logic                   mshr_empty_o;
    logic                   mshr_full_o;
    logic                   mshr_check_i;
    cache_pkg::nline_t      mshr_check_nline_i;
    logic                   mshr_check_hit_o;
    logic                   mshr_alloc_ready_o;
    logic                   mshr_alloc_i;
    cache_pkg::nline_t      mshr_alloc_nline_i;
    cache_pkg::sid_t        mshr_alloc_sid_i;
    cache_pkg::tid_t        mshr_alloc_tid_i;
    cache_pkg::word_idx_t   mshr_alloc_word_i;
    logic                   mshr_alloc_need_rsp_i;
    logic                   mem_req_ready_i;
    logic                   mem_req_valid_o;
    cache_pkg::nline_t      mem_req_nline_o;
    mem_pkg::mem_id_t       mem_req_id_o;
    logic                   mem_resp_ready_o;
    logic                   mem_resp_valid_i;
    mem_pkg::mem_id_t       mem_resp_id_i;
    mem_pkg::mem_resp_err_e mem_resp_error_i;
    logic                   mem_resp_last_i;
    cache_pkg::chunk_t      mem_resp_data_i;
    logic                   refill_req_ready_i;
    logic                   refill_req_valid_o;
    logic                   refill_busy_o;
    cache_pkg::way_vec_t    refill_victim_way_i;
    cache_pkg::way_vec_t    refill_victim_way_o;
    logic                   refill_write_data_o;
    logic                   refill_write_dir_o;
    cache_pkg::set_t        refill_set_o;
    cache_pkg::tag_t        refill_tag_o;
    cache_pkg::word_idx_t   refill_word_o;
    cache_pkg::chunk_t      refill_data_o;
    logic                   core_rsp_valid_o;
    cache_pkg::word_t       core_rsp_data_o;
    cache_pkg::sid_t        core_rsp_sid_o;
    cache_pkg::tid_t        core_rsp_tid_o;
    logic                   core_rsp_error_o;

    // Expected contents of each MSHR entry by memory ID
    cache_pkg::nline_t    e_nline [16];
    cache_pkg::word_idx_t e_word [16];
    cache_pkg::sid_t      e_sid [16];
    cache_pkg::tid_t      e_tid [16];
    logic                 e_need [16];
    logic                 e_err [16];
    logic                 e_valid [16];

    // Miss being allocated
    cache_pkg::nline_t    last_nline;
    cache_pkg::word_idx_t last_word;
    cache_pkg::sid_t      last_sid;
    cache_pkg::tid_t      last_tid;
    logic                 last_need;
    logic                 last_err;
    logic [3:0]           last_way;

    // Copy of the refilled miss taken at the grant
    cache_pkg::nline_t    r_nline;
    cache_pkg::word_idx_t r_word;
    cache_pkg::sid_t      r_sid;
    cache_pkg::tid_t      r_tid;
    logic                 r_need;
    logic                 r_err;
    cache_pkg::way_vec_t  r_victim;

    int          req_q [$];
    int          done_q [$];
    int          outstanding;
    int          cur_id;
    int          beat;
    int          ref_id;
    int          chunk;
    logic        sending;
    logic        stress;
    logic        hold_mem;
    logic [31:0] lfsr_q = 32'hf055;

    tb_clock #(.Period(8.0), .ResetCycles(5)) u_clock (.clk_o(clk_i), .rst_no(rst_ni));

    miss_handler #(.MshrWays(Ways), .FifoDepth(2)) uut (.*);

    function automatic logic next_bit();
        logic b;
        b = lfsr_q[0];
        lfsr_q = lfsr_q >> 1;
        if (b) lfsr_q = lfsr_q ^ 32'h8020_0003;
        return b;
    endfunction

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) v = {v[30:0], next_bit()};
        return v;
    endfunction

    // Word k of line L holds L * 16 + k
    function automatic cache_pkg::word_t ref_word(cache_pkg::nline_t l, int k);
        return cache_pkg::word_t'(l * 16 + k);
    endfunction

    task automatic fail_now(string what);
        $display("%0t: %s", $time, what);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic compare(string name, logic [63:0] got, logic [63:0] exp);
        if (got !== exp) begin
            $display("FAIL %0t %s got %0h expected %0h", $time, name, got, exp);
            $display("Some tests failed");
            $fatal(1);
        end
    endtask

    // Memory model with handshakes judged on values held until the next rising edge
    always @(negedge clk_i) begin
        mem_req_ready_i     = stress ? next_bit() : 1'b1;
        refill_req_ready_i  = stress ? next_bit() : 1'b1;
        refill_victim_way_i = cache_pkg::way_vec_t'(1) << rand_bits(2);
        if (!sending && req_q.size() > 0 && !hold_mem) begin
            cur_id  = rand_bits(4) % req_q.size();
            cur_id  = req_q[cur_id];
            req_q   = req_q.find(x) with (x != cur_id);
            beat    = 0;
            sending = 1'b1;
        end
        mem_resp_valid_i = sending && (stress ? next_bit() : 1'b1);
        mem_resp_id_i    = mem_pkg::mem_id_t'(cur_id);
        mem_resp_error_i = e_err[cur_id] ? mem_pkg::NOK : mem_pkg::OK;
        mem_resp_last_i  = (beat == Last);
        mem_resp_data_i[0] = ref_word(e_nline[cur_id], 2 * beat);
        mem_resp_data_i[1] = ref_word(e_nline[cur_id], 2 * beat + 1);
        #1;
        if (mem_req_valid_o && mem_req_ready_i) begin
            compare("mem_req_nline_o", mem_req_nline_o, last_nline);
            compare("mem_req_id_o", mem_req_id_o, last_way);
            e_nline[last_way] = last_nline;
            e_sid[last_way]   = last_sid;
            e_tid[last_way]   = last_tid;
            e_word[last_way]  = last_word;
            e_need[last_way]  = last_need;
            e_err[last_way]   = last_err;
            req_q.push_back(last_way);
        end
        if (mem_resp_valid_i && mem_resp_ready_o) begin
            beat++;
            if (mem_resp_last_i) begin
                done_q.push_back(cur_id);
                sending = 1'b0;
            end
        end
    end

    // Checker of refill writes and core responses
    always @(negedge clk_i) begin
        logic exp_rsp;
        #2;
        if (refill_req_valid_o && refill_req_ready_i) begin
            if (done_q.size() == 0) begin
                fail_now("refill granted without a completed response");
            end else begin
                ref_id  = done_q.pop_front();
                r_nline = e_nline[ref_id];
                r_word  = e_word[ref_id];
                r_sid   = e_sid[ref_id];
                r_tid   = e_tid[ref_id];
                r_need  = e_need[ref_id];
                r_err   = e_err[ref_id];
                e_valid[ref_id] = 1'b0;
                chunk = 0;
            end
        end
        if (refill_busy_o) begin
            // Victim way is taken in the first write cycle
            if (chunk == 0) begin
                r_victim = refill_victim_way_i;
            end
            compare("refill_write_data_o", refill_write_data_o, !r_err);
            compare("refill_write_dir_o", refill_write_dir_o, !r_err && chunk == Last);
            if (!r_err) begin
                compare("refill_word_o", refill_word_o, 2 * chunk);
                compare("refill_data_o[0]", refill_data_o[0], ref_word(r_nline, 2 * chunk));
                compare("refill_data_o[1]", refill_data_o[1], ref_word(r_nline, 2 * chunk + 1));
                compare("refill_victim_way_o", refill_victim_way_o, r_victim);
            end
            if (!r_err && chunk == Last) begin
                compare("refill_set_o", refill_set_o, r_nline[5:0]);
                compare("refill_tag_o", refill_tag_o, r_nline[25:6]);
            end
            exp_rsp = r_need && (r_word / 2 == chunk);
            compare("core_rsp_valid_o", core_rsp_valid_o, exp_rsp);
            if (exp_rsp) begin
                if (!r_err) begin
                    compare("core_rsp_data_o", core_rsp_data_o, ref_word(r_nline, r_word));
                end
                compare("core_rsp_sid_o", core_rsp_sid_o, r_sid);
                compare("core_rsp_tid_o", core_rsp_tid_o, r_tid);
                compare("core_rsp_error_o", core_rsp_error_o, r_err);
            end
            if (chunk == Last) begin
                outstanding--;
            end
            chunk++;
        end else begin
            compare("core_rsp_valid_o", core_rsp_valid_o, 1'b0);
            compare("refill_write_data_o", refill_write_data_o, 1'b0);
            compare("refill_write_dir_o", refill_write_dir_o, 1'b0);
        end
    end

    task automatic alloc(cache_pkg::nline_t l, int word, logic need, logic err);
        int t;
        t = 0;
        @(negedge clk_i);
        while (!mshr_alloc_ready_o || mshr_full_o) begin
            t++;
            if (t > 500) fail_now("allocation never became ready");
            @(negedge clk_i);
        end
        last_way = 0;
        for (int i = Ways - 1; i >= 0; i--) begin
            if (!e_valid[i]) begin
                last_way = 4'(i);
            end
        end
        last_nline = l;
        last_word  = cache_pkg::word_idx_t'(word);
        last_need  = need;
        last_err   = err;
        last_sid   = cache_pkg::sid_t'(rand_bits(2));
        last_tid   = cache_pkg::tid_t'(rand_bits(4));
        e_valid[last_way] = 1'b1;
        outstanding++;
        mshr_alloc_i          = 1'b1;
        mshr_alloc_nline_i    = l;
        mshr_alloc_word_i     = last_word;
        mshr_alloc_sid_i      = last_sid;
        mshr_alloc_tid_i      = last_tid;
        mshr_alloc_need_rsp_i = need;
        @(negedge clk_i);
        mshr_alloc_i = 1'b0;
    endtask

    task automatic wait_idle();
        int t;
        t = 0;
        while (outstanding != 0) begin
            t++;
            if (t > 5000) fail_now("misses did not complete in time");
            @(negedge clk_i);
        end
        @(negedge clk_i);
        compare("mshr_empty_o", mshr_empty_o, 1'b1);
    endtask

    task automatic check_line(cache_pkg::nline_t l, logic exp);
        @(negedge clk_i);
        mshr_check_i       = 1'b1;
        mshr_check_nline_i = l;
        #1;
        compare("mshr_check_hit_o", mshr_check_hit_o, exp);
        mshr_check_i = 1'b0;
    endtask

    initial begin
        int t;
        mshr_check_i          = 1'b0;
        mshr_check_nline_i    = '0;
        mshr_alloc_i          = 1'b0;
        mshr_alloc_nline_i    = '0;
        mshr_alloc_sid_i      = '0;
        mshr_alloc_tid_i      = '0;
        mshr_alloc_word_i     = '0;
        mshr_alloc_need_rsp_i = 1'b0;
        mem_req_ready_i       = 1'b0;
        mem_resp_valid_i      = 1'b0;
        mem_resp_id_i         = '0;
        mem_resp_error_i      = mem_pkg::OK;
        mem_resp_last_i       = 1'b0;
        mem_resp_data_i       = '0;
        refill_req_ready_i    = 1'b0;
        refill_victim_way_i   = 4'b0010;
        sending               = 1'b0;
        stress                = 1'b0;
        hold_mem              = 1'b0;
        outstanding           = 0;
        cur_id                = 0;
        for (int i = 0; i < 16; i++) begin
            e_valid[i] = 1'b0;
            e_err[i]   = 1'b0;
            e_nline[i] = '0;
        end
        t = 0;
        while (rst_ni !== 1'b1) begin
            t++;
            if (t > 100) fail_now("reset never released");
            @(negedge clk_i);
        end
        compare("mem_req_valid_o", mem_req_valid_o, 1'b0);
        compare("refill_req_valid_o", refill_req_valid_o, 1'b0);
        compare("refill_busy_o", refill_busy_o, 1'b0);
        compare("mshr_full_o", mshr_full_o, 1'b0);
        compare("mshr_alloc_ready_o", mshr_alloc_ready_o, 1'b1);
        compare("mshr_empty_o", mshr_empty_o, 1'b1);
        // Single miss, then no response wanted, then an error response
        alloc(26'h12345, 5, 1'b1, 1'b0);
        wait_idle();
        alloc(26'h00a10, 2, 1'b0, 1'b0);
        wait_idle();
        alloc(26'h0beef, 7, 1'b1, 1'b1);
        wait_idle();
        // Several outstanding misses held back by the memory
        hold_mem = 1'b1;
        for (int i = 0; i < Ways; i++) begin
            alloc(26'h200 + 26'(i * 3), i, 1'b1, 1'b0);
        end
        t = 0;
        while (req_q.size() < Ways) begin
            t++;
            if (t > 200) fail_now("memory requests were not issued");
            @(negedge clk_i);
        end
        compare("mshr_full_o", mshr_full_o, 1'b1);
        compare("mshr_empty_o", mshr_empty_o, 1'b0);
        check_line(26'h203, 1'b1);
        hold_mem = 1'b0;
        wait_idle();
        check_line(26'h203, 1'b0);
        // Random back-pressure everywhere
        stress = 1'b1;
        for (int i = 0; i < 16; i++) begin
            alloc(cache_pkg::nline_t'(rand_bits(26)), int'(rand_bits(3)), next_bit(),
                  rand_bits(3) == 0);
        end
        wait_idle();
        $display("All tests passed");
        $finish;
    end

endmodule

/* verilog/cache_pkg.sv */
package cache_pkg;

    // Core word and cache line geometry
    localparam int WORD_WIDTH      = 32;
    localparam int LINE_WORDS      = 8;

    // A chunk is written per refill cycle and is also one memory beat
    localparam int CHUNK_WORDS     = 2;
    localparam int CHUNKS_PER_LINE = LINE_WORDS / CHUNK_WORDS;

    // Ways of the data cache, victim selection is one-hot
    localparam int CACHE_WAYS      = 4;

    // Line number is tag above set
    localparam int SET_WIDTH       = 6;
    localparam int TAG_WIDTH       = 20;

    typedef logic [WORD_WIDTH-1:0]          word_t;
    typedef logic [$clog2(LINE_WORDS)-1:0]  word_idx_t;
    typedef word_t [CHUNK_WORDS-1:0]        chunk_t;
    typedef logic [TAG_WIDTH+SET_WIDTH-1:0] nline_t;
    typedef logic [SET_WIDTH-1:0]           set_t;
    typedef logic [TAG_WIDTH-1:0]           tag_t;
    typedef logic [CACHE_WAYS-1:0]          way_vec_t;

    // Requester identifiers
    typedef logic [1:0] sid_t;
    typedef logic [3:0] tid_t;

endpackage

/* verilog/mem_pkg.sv */
package mem_pkg;

    // Memory transaction ID, carries the MSHR entry number
    localparam int MEM_ID_WIDTH = 4;

    typedef logic [MEM_ID_WIDTH-1:0] mem_id_t;

    typedef enum logic {
        OK  = 1'b0,
        NOK = 1'b1
    } mem_resp_err_e;

    // Completion record of one line response
    typedef struct packed {
        mem_resp_err_e error;
        mem_id_t       id;
    } resp_meta_t;

endpackage

/* verilog/miss_handler.sv */
`timescale 1ns/100ps

module miss_handler #(
    parameter int MshrWays  = 4,
    parameter int FifoDepth = 2
) (
    input  logic                  clk_i,
    input  logic                  rst_ni,

    output logic                  mshr_empty_o,
    output logic                  mshr_full_o,

    input  logic                  mshr_check_i,
    input  cache_pkg::nline_t     mshr_check_nline_i,
    output logic                  mshr_check_hit_o,

    output logic                  mshr_alloc_ready_o,
    input  logic                  mshr_alloc_i,
    input  cache_pkg::nline_t     mshr_alloc_nline_i,
    input  cache_pkg::sid_t       mshr_alloc_sid_i,
    input  cache_pkg::tid_t       mshr_alloc_tid_i,
    input  cache_pkg::word_idx_t  mshr_alloc_word_i,
    input  logic                  mshr_alloc_need_rsp_i,

    input  logic                  mem_req_ready_i,
    output logic                  mem_req_valid_o,
    output cache_pkg::nline_t     mem_req_nline_o,
    output mem_pkg::mem_id_t      mem_req_id_o,

    output logic                  mem_resp_ready_o,
    input  logic                  mem_resp_valid_i,
    input  mem_pkg::mem_id_t      mem_resp_id_i,
    input  mem_pkg::mem_resp_err_e mem_resp_error_i,
    input  logic                  mem_resp_last_i,
    input  cache_pkg::chunk_t     mem_resp_data_i,

    input  logic                  refill_req_ready_i,
    output logic                  refill_req_valid_o,
    output logic                  refill_busy_o,
    input  cache_pkg::way_vec_t   refill_victim_way_i,
    output cache_pkg::way_vec_t   refill_victim_way_o,
    output logic                  refill_write_data_o,
    output logic                  refill_write_dir_o,
    output cache_pkg::set_t       refill_set_o,
    output cache_pkg::tag_t       refill_tag_o,
    output cache_pkg::word_idx_t  refill_word_o,
    output cache_pkg::chunk_t     refill_data_o,

    output logic                  core_rsp_valid_o,
    output cache_pkg::word_t      core_rsp_data_o,
    output cache_pkg::sid_t       core_rsp_sid_o,
    output cache_pkg::tid_t       core_rsp_tid_o,
    output logic                  core_rsp_error_o
);

    logic                mshr_alloc;
    mem_pkg::mem_id_t    mshr_alloc_way;
    logic                mshr_empty;

    mem_pkg::resp_meta_t meta_wdata;
    mem_pkg::resp_meta_t meta_rdata;
    logic                meta_w;
    logic                meta_wok;
    logic                meta_r;
    logic                meta_rok;
    logic                data_w;
    logic                data_wok;
    logic                data_r;

    mshr_ack_if #(.MshrWays(MshrWays)) ack_if ();

    miss_issue #(
        .MshrWays (MshrWays)
    ) u_issue (
        .clk_i,
        .rst_ni,
        .alloc_i         (mshr_alloc_i),
        .alloc_nline_i   (mshr_alloc_nline_i),
        .alloc_way_i     (mshr_alloc_way),
        .alloc_ready_o   (mshr_alloc_ready_o),
        .alloc_o         (mshr_alloc),
        .mem_req_ready_i,
        .mem_req_valid_o,
        .mem_req_nline_o,
        .mem_req_id_o
    );

    mshr #(
        .MshrWays (MshrWays)
    ) u_mshr (
        .clk_i,
        .rst_ni,
        .alloc_i          (mshr_alloc),
        .alloc_nline_i    (mshr_alloc_nline_i),
        .alloc_sid_i      (mshr_alloc_sid_i),
        .alloc_tid_i      (mshr_alloc_tid_i),
        .alloc_word_i     (mshr_alloc_word_i),
        .alloc_need_rsp_i (mshr_alloc_need_rsp_i),
        .alloc_way_o      (mshr_alloc_way),
        .check_i          (mshr_check_i),
        .check_nline_i    (mshr_check_nline_i),
        .check_hit_o      (mshr_check_hit_o),
        .empty_o          (mshr_empty),
        .full_o           (mshr_full_o),
        .ack              (ack_if.store)
    );

    // Last beat needs room in both FIFOs, the others only in the data FIFO
    assign mem_resp_ready_o = data_wok & (meta_wok | ~mem_resp_last_i);
    assign data_w           = mem_resp_valid_i & mem_resp_ready_o;
    assign meta_w           = data_w & mem_resp_last_i;
    assign meta_wdata       = '{error: mem_resp_error_i, id: mem_resp_id_i};

    refill_fifo #(
        .payload_t (mem_pkg::resp_meta_t),
        .Depth     (FifoDepth)
    ) u_meta_fifo (
        .clk_i,
        .rst_ni,
        .w_i     (meta_w),
        .wdata_i (meta_wdata),
        .wok_o   (meta_wok),
        .r_i     (meta_r),
        .rok_o   (meta_rok),
        .rdata_o (meta_rdata)
    );

    // Data is present whenever its metadata is, so the read side needs no flag
    refill_fifo #(
        .payload_t (cache_pkg::chunk_t),
        .Depth     (FifoDepth * cache_pkg::CHUNKS_PER_LINE)
    ) u_data_fifo (
        .clk_i,
        .rst_ni,
        .w_i     (data_w),
        .wdata_i (mem_resp_data_i),
        .wok_o   (data_wok),
        .r_i     (data_r),
        .rok_o   (),
        .rdata_o (refill_data_o)
    );

    refill_ctrl #(
        .MshrWays (MshrWays)
    ) u_refill (
        .clk_i,
        .rst_ni,
        .meta_rok_i          (meta_rok),
        .meta_i              (meta_rdata),
        .meta_r_o            (meta_r),
        .data_i              (refill_data_o),
        .data_r_o            (data_r),
        .refill_req_ready_i,
        .refill_req_valid_o,
        .refill_busy_o,
        .refill_victim_way_i,
        .refill_victim_way_o,
        .refill_write_data_o,
        .refill_write_dir_o,
        .refill_set_o,
        .refill_tag_o,
        .refill_word_o,
        .core_rsp_valid_o,
        .core_rsp_data_o,
        .core_rsp_sid_o,
        .core_rsp_tid_o,
        .core_rsp_error_o,
        .ack                 (ack_if.refill)
    );

    // No miss left once the MSHR is empty and the last refill is written
    assign mshr_empty_o = mshr_empty & ~refill_busy_o;

endmodule

/* verilog/miss_issue.sv */
`timescale 1ns/100ps

module miss_issue #(
    parameter int MshrWays = 4
) (
    input  logic              clk_i,
    input  logic              rst_ni,

    input  logic              alloc_i,
    input  cache_pkg::nline_t alloc_nline_i,
    input  mem_pkg::mem_id_t  alloc_way_i,
    output logic              alloc_ready_o,
    output logic              alloc_o,

    input  logic              mem_req_ready_i,
    output logic              mem_req_valid_o,
    output cache_pkg::nline_t mem_req_nline_o,
    output mem_pkg::mem_id_t  mem_req_id_o
);

    localparam int WayWidth = (MshrWays > 1) ? $clog2(MshrWays) : 1;

    typedef enum logic {
        IDLE = 1'b0,
        SEND = 1'b1
    } state_e;

    state_e              state_q;
    cache_pkg::nline_t   nline_q;
    logic [WayWidth-1:0] way_q;

    // New misses only while no request is in flight
    assign alloc_ready_o   = (state_q == IDLE);
    assign alloc_o         = alloc_ready_o & alloc_i;
    assign mem_req_valid_o = (state_q == SEND);
    assign mem_req_nline_o = nline_q;
    assign mem_req_id_o    = mem_pkg::mem_id_t'(way_q);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
        end else if (alloc_o) begin
            state_q <= SEND;
        end else if (mem_req_valid_o && mem_req_ready_i) begin
            state_q <= IDLE;
        end
    end

    always_ff @(posedge clk_i) begin
        if (alloc_o) begin
            nline_q <= alloc_nline_i;
            way_q   <= alloc_way_i[WayWidth-1:0];
        end
    end

endmodule

/* verilog/mshr.sv */
`timescale 1ns/100ps

module mshr #(
    parameter int MshrWays = 4,
    localparam int WayWidth = (MshrWays > 1) ? $clog2(MshrWays) : 1
) (
    input  logic                 clk_i,
    input  logic                 rst_ni,

    input  logic                 alloc_i,
    input  cache_pkg::nline_t    alloc_nline_i,
    input  cache_pkg::sid_t      alloc_sid_i,
    input  cache_pkg::tid_t      alloc_tid_i,
    input  cache_pkg::word_idx_t alloc_word_i,
    input  logic                 alloc_need_rsp_i,
    output mem_pkg::mem_id_t     alloc_way_o,

    input  logic                 check_i,
    input  cache_pkg::nline_t    check_nline_i,
    output logic                 check_hit_o,

    output logic                 empty_o,
    output logic                 full_o,

    mshr_ack_if.store            ack
);

    typedef struct packed {
        cache_pkg::nline_t    nline;
        cache_pkg::sid_t      sid;
        cache_pkg::tid_t      tid;
        cache_pkg::word_idx_t word;
        logic                 need_rsp;
    } entry_t;

    logic [MshrWays-1:0] valid_q;
    entry_t              entry_q [MshrWays];
    logic [WayWidth-1:0] free_way;
    entry_t              ack_entry;

    // Lowest-numbered invalid entry
    always_comb begin
        free_way = '0;
        for (int i = MshrWays - 1; i >= 0; i--) begin
            if (!valid_q[i]) begin
                free_way = WayWidth'(i);
            end
        end
    end

    assign alloc_way_o = mem_pkg::mem_id_t'(free_way);
    assign full_o      = &valid_q;
    assign empty_o     = ~|valid_q;

    always_comb begin
        check_hit_o = 1'b0;
        for (int i = 0; i < MshrWays; i++) begin
            if (check_i && valid_q[i] && (entry_q[i].nline == check_nline_i)) begin
                check_hit_o = 1'b1;
            end
        end
    end

    // Free entry and acknowledged entry are never the same one
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
        end else begin
            if (alloc_i) begin
                valid_q[free_way] <= 1'b1;
            end
            if (ack.ack) begin
                valid_q[ack.way] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (alloc_i) begin
            entry_q[free_way] <= '{
                nline:    alloc_nline_i,
                sid:      alloc_sid_i,
                tid:      alloc_tid_i,
                word:     alloc_word_i,
                need_rsp: alloc_need_rsp_i
            };
        end
    end

    // Entry read, contents still valid in the cycle after release
    assign ack_entry    = ack.ack_cs ? entry_q[ack.way] : '0;
    assign ack.nline    = ack_entry.nline;
    assign ack.sid      = ack_entry.sid;
    assign ack.tid      = ack_entry.tid;
    assign ack.word     = ack_entry.word;
    assign ack.need_rsp = ack_entry.need_rsp;

endmodule

/* verilog/mshr_ack_if.sv */
`timescale 1ns/100ps

interface mshr_ack_if #(
    parameter int MshrWays = 4
);

    localparam int WayWidth = (MshrWays > 1) ? $clog2(MshrWays) : 1;

    // Release strobe, read enable and selected entry
    logic                 ack;
    logic                 ack_cs;
    logic [WayWidth-1:0]  way;

    // Contents of the selected entry
    cache_pkg::nline_t    nline;
    cache_pkg::sid_t      sid;
    cache_pkg::tid_t      tid;
    cache_pkg::word_idx_t word;
    logic                 need_rsp;

    modport refill (
        output ack, ack_cs, way,
        input  nline, sid, tid, word, need_rsp
    );

    modport store (
        input  ack, ack_cs, way,
        output nline, sid, tid, word, need_rsp
    );

endinterface

/* verilog/refill_ctrl.sv */
`timescale 1ns/100ps

module refill_ctrl #(
    parameter int MshrWays = 4
) (
    input  logic                 clk_i,
    input  logic                 rst_ni,

    input  logic                 meta_rok_i,
    input  mem_pkg::resp_meta_t  meta_i,
    output logic                 meta_r_o,
    input  cache_pkg::chunk_t    data_i,
    output logic                 data_r_o,

    input  logic                 refill_req_ready_i,
    output logic                 refill_req_valid_o,
    output logic                 refill_busy_o,
    input  cache_pkg::way_vec_t  refill_victim_way_i,
    output cache_pkg::way_vec_t  refill_victim_way_o,
    output logic                 refill_write_data_o,
    output logic                 refill_write_dir_o,
    output cache_pkg::set_t      refill_set_o,
    output cache_pkg::tag_t      refill_tag_o,
    output cache_pkg::word_idx_t refill_word_o,

    output logic                 core_rsp_valid_o,
    output cache_pkg::word_t     core_rsp_data_o,
    output cache_pkg::sid_t      core_rsp_sid_o,
    output cache_pkg::tid_t      core_rsp_tid_o,
    output logic                 core_rsp_error_o,

    mshr_ack_if.refill           ack
);

    localparam int WayWidth  = (MshrWays > 1) ? $clog2(MshrWays) : 1;
    localparam int SelWidth  = (cache_pkg::CHUNK_WORDS > 1) ? $clog2(cache_pkg::CHUNK_WORDS) : 1;
    localparam cache_pkg::word_idx_t ChunkStep = cache_pkg::word_idx_t'(cache_pkg::CHUNK_WORDS);
    localparam cache_pkg::word_idx_t LastWord  =
        cache_pkg::word_idx_t'(cache_pkg::LINE_WORDS - cache_pkg::CHUNK_WORDS);

    typedef enum logic {
        IDLE  = 1'b0,
        WRITE = 1'b1
    } state_e;

    state_e               state_q;
    state_e               state_d;
    cache_pkg::word_idx_t cnt_q;
    logic                 grant;
    logic                 writing;
    logic                 first_chunk;
    logic                 last_chunk;
    logic                 is_error;

    cache_pkg::set_t      set_q;
    cache_pkg::tag_t      tag_q;
    cache_pkg::way_vec_t  way_q;
    cache_pkg::sid_t      sid_q;
    cache_pkg::tid_t      tid_q;
    cache_pkg::word_idx_t rsp_word_q;
    logic                 need_rsp_q;

    cache_pkg::word_idx_t rsp_word;
    logic                 need_rsp;
    logic [SelWidth-1:0]  word_sel;

    assign writing     = (state_q == WRITE);
    assign first_chunk = writing && (cnt_q == '0);
    assign last_chunk  = writing && (cnt_q == LastWord);
    assign grant       = (state_q == IDLE) && meta_rok_i && refill_req_ready_i;
    assign is_error    = (meta_i.error == mem_pkg::NOK);

    // Entry is read ahead of the grant and held through the first chunk
    assign ack.way    = meta_i.id[WayWidth-1:0];
    assign ack.ack_cs = ((state_q == IDLE) && meta_rok_i) || first_chunk;
    assign ack.ack    = grant;

    assign refill_req_valid_o = (state_q == IDLE) && meta_rok_i;
    assign refill_busy_o      = writing;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (grant) begin
                    state_d = WRITE;
                end
            end
            WRITE: begin
                if (last_chunk) begin
                    state_d = IDLE;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    // First chunk takes the MSHR contents and the live victim way
    assign refill_set_o        = first_chunk ? ack.nline[cache_pkg::SET_WIDTH-1:0] : set_q;
    assign refill_tag_o        = first_chunk ?
                                 ack.nline[cache_pkg::SET_WIDTH +: cache_pkg::TAG_WIDTH] : tag_q;
    assign refill_victim_way_o = first_chunk ? refill_victim_way_i : way_q;
    assign core_rsp_sid_o      = first_chunk ? ack.sid : sid_q;
    assign core_rsp_tid_o      = first_chunk ? ack.tid : tid_q;
    assign rsp_word            = first_chunk ? ack.word : rsp_word_q;
    assign need_rsp            = first_chunk ? ack.need_rsp : need_rsp_q;

    // Chunk and memory are consumed even on error
    assign refill_word_o       = cnt_q;
    assign refill_write_data_o = writing && !is_error;
    assign refill_write_dir_o  = last_chunk && !is_error;
    assign data_r_o            = writing;
    assign meta_r_o            = last_chunk;

    // Requested word answers in the cycle of its chunk
    assign word_sel         = SelWidth'(rsp_word % ChunkStep);
    assign core_rsp_data_o  = data_i[word_sel];
    assign core_rsp_error_o = is_error;
    assign core_rsp_valid_o = writing && need_rsp && ((rsp_word / ChunkStep) == (cnt_q / ChunkStep));

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
            cnt_q   <= '0;
        end else begin
            state_q <= state_d;
            // Counter wraps back to zero after the last chunk
            if (writing) begin
                cnt_q <= cnt_q + ChunkStep;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (first_chunk) begin
            set_q      <= refill_set_o;
            tag_q      <= refill_tag_o;
            way_q      <= refill_victim_way_i;
            sid_q      <= ack.sid;
            tid_q      <= ack.tid;
            rsp_word_q <= ack.word;
            need_rsp_q <= ack.need_rsp;
        end
    end

endmodule

/* verilog/refill_fifo.sv */
`timescale 1ns/100ps

module refill_fifo #(
    parameter type payload_t = logic,
    parameter int  Depth     = 2
) (
    input  logic     clk_i,
    input  logic     rst_ni,

    input  logic     w_i,
    input  payload_t wdata_i,
    output logic     wok_o,

    input  logic     r_i,
    output logic     rok_o,
    output payload_t rdata_o
);

    localparam int PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;

    payload_t            mem_q [Depth];
    logic [PtrWidth-1:0] wptr_q;
    logic [PtrWidth-1:0] rptr_q;
    logic [PtrWidth:0]   count_q;
    logic                push;
    logic                pop;

    assign wok_o   = (count_q != (PtrWidth + 1)'(Depth));
    assign rok_o   = (count_q != '0);
    assign push    = w_i & wok_o;
    assign pop     = r_i & rok_o;
    assign rdata_o = mem_q[rptr_q];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wptr_q  <= '0;
            rptr_q  <= '0;
            count_q <= '0;
        end else begin
            if (push) begin
                // Pointers wrap at the depth, which need not be a power of two
                wptr_q <= (wptr_q == PtrWidth'(Depth - 1)) ? '0 : wptr_q + 1'b1;
            end
            if (pop) begin
                rptr_q <= (rptr_q == PtrWidth'(Depth - 1)) ? '0 : rptr_q + 1'b1;
            end
            if (push && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wptr_q] <= wdata_i;
        end
    end

endmodule
